//--- hdl/itrng_feed.sv
`include "rt_config.svh"

module itrng_feed
    import rt_pkg::*;
(
    input  logic    core_clk,
    input  logic    hwif_out,
    input  logic    etrng_req,
    output nibble_t itrng_data,
    output logic    itrng_valid,
    itrng_if.feed   bus
);

    localparam int PTR_W   = $clog2(`RT_TRNG_DEPTH);
    localparam int NIBBLES = `RT_DATA_W / `RT_NIB_W;
    localparam int IDX_W   = $clog2(NIBBLES);

    reg_data_t        mem [`RT_TRNG_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [IDX_W-1:0] nib_idx;
    reg_data_t        head_word;
    reg_data_t        throttle_cnt;
    logic             throttled_req;
    logic             serve;
    logic             last_nib;
    logic             do_push;
    logic             do_pop;

    assign bus.empty = (count == '0);
    assign bus.full  = (count == (PTR_W + 1)'(`RT_TRNG_DEPTH));

    assign head_word = mem[rd_ptr];
    assign serve     = throttled_req && !bus.empty && !bus.fifo_reset;
    assign last_nib  = (nib_idx == IDX_W'(NIBBLES - 1));

    // Word leaves once its last nibble is out
    assign do_pop  = serve && last_nib;
    assign do_push = bus.push && !bus.fifo_reset && (!bus.full || do_pop);

    // Request throttle
    // Samples etrng_req once every divisor+1 cycles
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt  <= '0;
            throttled_req <= 1'b0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt  <= bus.divisor;
            throttled_req <= etrng_req;
        end else begin
            throttle_cnt  <= throttle_cnt - 1'b1;
            throttled_req <= 1'b0;
        end
    end

    // FIFO control and nibble index
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (bus.fifo_reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= serve;
            // Index wraps to 0 after the eighth nibble
            if (serve) begin
                nib_idx <= nib_idx + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Word storage and nibble output, low nibble first
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= bus.word;
        end
        if (serve) begin
            itrng_data <= head_word[nib_idx * `RT_NIB_W +: `RT_NIB_W];
        end
    end

endmodule

//--- hdl/log_fifo.sv
`include "rt_config.svh"

module log_fifo
    import rt_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,
    input  logic      log_wr,
    input  log_char_t log_char,
    log_fifo_if.fifo  bus
);

    localparam int PTR_W = $clog2(`RT_LOG_DEPTH);

    log_char_t        mem [`RT_LOG_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign bus.valid = (count != '0);
    assign bus.full  = (count == (PTR_W + 1)'(`RT_LOG_DEPTH));
    assign bus.head  = mem[rd_ptr];

    // A pop frees a slot for a push in the same cycle
    assign do_pop  = bus.pop && bus.valid;
    assign do_push = log_wr && (!bus.full || do_pop);

    // Pointers and occupancy
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Character storage
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= log_char;
        end
    end

endmodule

//--- hdl/rt_config.svh
`ifndef RT_CONFIG_SVH
`define RT_CONFIG_SVH

// Datapath widths
`define RT_DATA_W 32
`define RT_ADDR_W 6
`define RT_CHAR_W 8
`define RT_NIB_W 4

// FIFO depths must be powers of two
`define RT_LOG_DEPTH 16
`define RT_TRNG_DEPTH 4

// Register byte offsets
`define RT_LOG_DATA 6'h00
`define RT_LOG_STATUS 6'h04
`define RT_ITRNG_DATA 6'h08
`define RT_ITRNG_STATUS 6'h0C
`define RT_ITRNG_DIV 6'h10
`define RT_CYCLE_COUNT 6'h14

`endif

//--- hdl/rt_ifs.sv
// Register block to log capture FIFO
interface log_fifo_if
    import rt_pkg::*;
();
    log_char_t head;
    logic      valid;
    logic      full;
    logic      pop;

    modport regs (
        input  head,
        input  valid,
        input  full,
        output pop
    );

    modport fifo (
        output head,
        output valid,
        output full,
        input  pop
    );
endinterface

// Register block to entropy feed
interface itrng_if
    import rt_pkg::*;
();
    logic      push;
    reg_data_t word;
    logic      fifo_reset;
    reg_data_t divisor;
    logic      empty;
    logic      full;

    modport regs (
        output push,
        output word,
        output fifo_reset,
        output divisor,
        input  empty,
        input  full
    );

    modport feed (
        input  push,
        input  word,
        input  fifo_reset,
        input  divisor,
        output empty,
        output full
    );
endinterface

//--- hdl/rt_pkg.sv
`include "rt_config.svh"

package rt_pkg;

    // Register port
    typedef logic [`RT_DATA_W-1:0] reg_data_t;
    typedef logic [`RT_ADDR_W-1:0] reg_addr_t;

    // Log capture character
    typedef logic [`RT_CHAR_W-1:0] log_char_t;

    // Entropy nibble toward the core
    typedef logic [`RT_NIB_W-1:0] nibble_t;

    // Decoded register select
    typedef enum logic [2:0] {
        SEL_LOG_DATA,
        SEL_LOG_STATUS,
        SEL_ITRNG_DATA,
        SEL_ITRNG_STATUS,
        SEL_ITRNG_DIV,
        SEL_CYCLE_COUNT,
        SEL_INVALID
    } reg_sel_e;

endpackage

//--- hdl/rt_regs.sv
`include "rt_config.svh"

module rt_regs
    import rt_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    log_fifo_if.regs  log_bus,
    itrng_if.regs     trng_bus
);

    reg_sel_e  sel;
    reg_data_t rd_mux;
    reg_data_t divisor_q;
    reg_data_t word_q;
    reg_data_t cycle_count;
    logic      fifo_rst_q;
    logic      push_q;
    logic      wr_trng_data;
    logic      wr_trng_status;
    logic      wr_trng_div;

    // Address decode
    always_comb begin
        case (reg_addr)
            `RT_LOG_DATA:     sel = SEL_LOG_DATA;
            `RT_LOG_STATUS:   sel = SEL_LOG_STATUS;
            `RT_ITRNG_DATA:   sel = SEL_ITRNG_DATA;
            `RT_ITRNG_STATUS: sel = SEL_ITRNG_STATUS;
            `RT_ITRNG_DIV:    sel = SEL_ITRNG_DIV;
            `RT_CYCLE_COUNT:  sel = SEL_CYCLE_COUNT;
            default:          sel = SEL_INVALID;
        endcase
    end

    assign wr_trng_data   = reg_wr && (sel == SEL_ITRNG_DATA);
    assign wr_trng_status = reg_wr && (sel == SEL_ITRNG_STATUS);
    assign wr_trng_div    = reg_wr && (sel == SEL_ITRNG_DIV);

    // Pop only when a character was there at the read edge
    assign log_bus.pop = reg_rd && (sel == SEL_LOG_DATA) && log_bus.valid;

    assign trng_bus.push       = push_q;
    assign trng_bus.word       = word_q;
    assign trng_bus.fifo_reset = fifo_rst_q;
    assign trng_bus.divisor    = divisor_q;

    // Control bits and the delayed entropy push
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor_q  <= '0;
            fifo_rst_q <= 1'b0;
            push_q     <= 1'b0;
        end else begin
            push_q <= wr_trng_data;
            if (wr_trng_div) begin
                divisor_q <= reg_wdata;
            end
            if (wr_trng_status) begin
                fifo_rst_q <= reg_wdata[2];
            end
        end
    end

    // Entropy word held for the push one cycle later
    always_ff @(posedge core_clk) begin
        if (wr_trng_data) begin
            word_q <= reg_wdata;
        end
    end

    // Free-running, wraps at the top
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Read mux
    // LOG_STATUS bit 0 = valid, bit 1 = full
    // ITRNG_STATUS bit 0 = empty, bit 1 = full, bit 2 = reset
    always_comb begin
        case (sel)
            SEL_LOG_DATA:     rd_mux = reg_data_t'({log_bus.valid, log_bus.head});
            SEL_LOG_STATUS:   rd_mux = reg_data_t'({log_bus.full, log_bus.valid});
            SEL_ITRNG_STATUS: rd_mux = reg_data_t'({fifo_rst_q, trng_bus.full, trng_bus.empty});
            SEL_ITRNG_DIV:    rd_mux = divisor_q;
            SEL_CYCLE_COUNT:  rd_mux = cycle_count;
            // ITRNG_DATA is write only
            default:          rd_mux = '0;
        endcase
    end

    // Read data lands one cycle after the strobe
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

//--- hdl/rt_top.sv
module rt_top
    import rt_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    input  logic      log_wr,
    input  log_char_t log_char,
    input  logic      etrng_req,
    output nibble_t   itrng_data,
    output logic      itrng_valid
);

    log_fifo_if log_bus ();
    itrng_if    trng_bus ();

    // Register block steering both FIFOs
    rt_regs u_regs (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .log_bus   (log_bus.regs),
        .trng_bus  (trng_bus.regs)
    );

    // Firmware characters into the log FIFO
    log_fifo u_log_fifo (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .log_wr   (log_wr),
        .log_char (log_char),
        .bus      (log_bus.fifo)
    );

    itrng_feed u_itrng_feed (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .bus         (trng_bus.feed)
    );

endmodule

//--- project.f
+incdir+hdl
hdl/rt_pkg.sv
hdl/rt_ifs.sv
hdl/log_fifo.sv
hdl/itrng_feed.sv
hdl/rt_regs.sv
hdl/rt_top.sv
verification/rt_tb.sv

//--- verification/rt_tb.sv
`include "rt_config.svh"

module rt_tb
    import rt_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {
        K_WR,
        K_RD,
        K_CHAR,
        K_NIB,
        K_GAP,
        K_QUIET,
        K_CYC
    } kind_e;

    localparam int STEP_CYCLES  = 40;
    localparam int WATCH_MARGIN = 200;
    localparam int PULSE_WAIT   = 64;

    logic      core_clk = 1'b0;
    logic      hwif_out;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      log_wr;
    log_char_t log_char;
    logic      etrng_req;
    nibble_t   itrng_data;
    logic      itrng_valid;

    // Stimulus table with one queue per column
    // Data holds the compare mask for reads and the spacing for gap steps
    string     t_name[$];
    kind_e     t_kind[$];
    reg_addr_t t_addr[$];
    reg_data_t t_data[$];
    reg_data_t t_exp[$];

    integer seed       = 32'hf46b_c034;
    int     cyc        = 0;
    int     last_pulse = 0;
    int     test_errs  = 0;
    int     tests_ok   = 0;
    int     tests_bad  = 0;
    int     table_len  = 0;

    rt_top dut_i (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .log_wr      (log_wr),
        .log_char    (log_char),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    always #5 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cyc <= cyc + 1;
    end

    task automatic add_step(input string name, input kind_e kind, input reg_addr_t addr,
                            input reg_data_t data, input reg_data_t exp);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_exp.push_back(exp);
    endtask

    // LOG_DATA word with the valid bit set
    function automatic reg_data_t char_word(input log_char_t c);
        return {23'b0, 1'b1, c};
    endfunction

    task automatic build_table();
        log_char_t chars[$];
        log_char_t c;
        nibble_t   nibs[8] = '{4'hd, 4'h0, 4'h0, 4'hf, 4'hd, 4'ha, 4'hb, 4'h8};
        add_step("reset_state", K_QUIET, '0, 4, 0);
        add_step("reset_state", K_RD, `RT_LOG_STATUS, '1, 0);
        add_step("reset_state", K_RD, `RT_ITRNG_STATUS, '1, 1);
        add_step("reset_state", K_RD, `RT_ITRNG_DIV, '1, 0);
        for (int i = 0; i < 5; i++) begin
            c = log_char_t'($random(seed));
            chars.push_back(c);
            add_step("log_order", K_CHAR, '0, reg_data_t'(c), 0);
        end
        for (int i = 0; i < 5; i++) begin
            add_step("log_order", K_RD, `RT_LOG_DATA, '1, char_word(chars[i]));
        end
        add_step("log_order", K_RD, `RT_LOG_DATA, 32'h100, 0);
        // 18 pushes into 16 slots drop the last two
        chars.delete();
        for (int i = 0; i < 18; i++) begin
            c = log_char_t'($random(seed));
            chars.push_back(c);
            add_step("log_overflow", K_CHAR, '0, reg_data_t'(c), 0);
        end
        add_step("log_overflow", K_RD, `RT_LOG_STATUS, '1, 3);
        for (int i = 0; i < 16; i++) begin
            add_step("log_overflow", K_RD, `RT_LOG_DATA, '1, char_word(chars[i]));
        end
        add_step("log_overflow", K_RD, `RT_LOG_DATA, 32'h100, 0);
        add_step("nibble_delivery", K_WR, `RT_ITRNG_DIV, 0, 0);
        add_step("nibble_delivery", K_WR, `RT_ITRNG_DATA, 32'h8bad_f00d, 0);
        for (int i = 0; i < 8; i++) begin
            add_step("nibble_delivery", K_NIB, '0, 0, reg_data_t'(nibs[i]));
        end
        add_step("nibble_delivery", K_RD, `RT_ITRNG_STATUS, '1, 1);
        // Two words whose nibbles count 0 to f
        add_step("throttle", K_WR, `RT_ITRNG_DIV, 5, 0);
        add_step("throttle", K_WR, `RT_ITRNG_DATA, 32'h7654_3210, 0);
        add_step("throttle", K_WR, `RT_ITRNG_DATA, 32'hfedc_ba98, 0);
        add_step("throttle", K_NIB, '0, 0, 0);
        for (int i = 1; i < 16; i++) begin
            add_step("throttle", K_GAP, '0, 6, reg_data_t'(i));
        end
        add_step("fifo_reset", K_WR, `RT_ITRNG_DATA, 32'h1234_5678, 0);
        add_step("fifo_reset", K_WR, `RT_ITRNG_STATUS, 32'h4, 0);
        add_step("fifo_reset", K_RD, `RT_ITRNG_STATUS, '1, 5);
        add_step("fifo_reset", K_WR, `RT_ITRNG_STATUS, 32'h0, 0);
        add_step("fifo_reset", K_RD, `RT_ITRNG_STATUS, '1, 1);
        add_step("fifo_reset", K_QUIET, '0, 20, 0);
        add_step("cycle_counter", K_CYC, `RT_CYCLE_COUNT, 7, 7);
    endtask

    // Data is taken one cycle after the strobe
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge core_clk);
        etrng_req <= 1'b0;
        reg_rd    <= 1'b1;
        reg_addr  <= addr;
        @(posedge core_clk);
        reg_rd <= 1'b0;
        @(negedge core_clk);
        data = reg_rdata;
    endtask

    // Holds the request and looks for the next itrng_valid cycle
    task automatic wait_pulse(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        if (!etrng_req) begin
            @(posedge core_clk);
            etrng_req <= 1'b1;
        end
        while (!seen && waited < PULSE_WAIT) begin
            @(negedge core_clk);
            waited++;
            seen = itrng_valid;
        end
    endtask

    task automatic run_step(input int i);
        reg_data_t got;
        reg_data_t first;
        int        pulses;
        int        gap;
        bit        seen;
        case (t_kind[i])
            K_WR: begin
                @(posedge core_clk);
                etrng_req <= 1'b0;
                reg_wr    <= 1'b1;
                reg_addr  <= t_addr[i];
                reg_wdata <= t_data[i];
                @(posedge core_clk);
                reg_wr <= 1'b0;
            end
            K_RD: begin
                read_reg(t_addr[i], got);
                assert ((got & t_data[i]) === t_exp[i]) else begin
                    $display("FAIL %s: expected %h, actual %h", t_name[i], t_exp[i],
                             got & t_data[i]);
                    test_errs++;
                end
            end
            K_CHAR: begin
                @(posedge core_clk);
                etrng_req <= 1'b0;
                log_wr    <= 1'b1;
                log_char  <= t_data[i][7:0];
                @(posedge core_clk);
                log_wr <= 1'b0;
            end
            K_NIB, K_GAP: begin
                wait_pulse(seen);
                assert (seen) else begin
                    $display("%s: no itrng_valid pulse within %0d cycles", t_name[i],
                             PULSE_WAIT);
                    test_errs++;
                end
                if (seen) begin
                    assert (itrng_data === t_exp[i][3:0]) else begin
                        $display("FAIL %s: expected nibble %h, actual %h", t_name[i],
                                 t_exp[i][3:0], itrng_data);
                        test_errs++;
                    end
                    gap = cyc - last_pulse;
                    if (t_kind[i] == K_GAP) begin
                        assert (gap == int'(t_data[i])) else begin
                            $display("FAIL %s: expected spacing %0d, actual %0d", t_name[i],
                                     t_data[i], gap);
                            test_errs++;
                        end
                    end
                    last_pulse = cyc;
                end
            end
            K_QUIET: begin
                pulses = 0;
                @(posedge core_clk);
                etrng_req <= 1'b1;
                repeat (t_data[i]) begin
                    @(negedge core_clk);
                    if (itrng_valid !== 1'b0) begin
                        pulses++;
                    end
                end
                assert (pulses == int'(t_exp[i])) else begin
                    $display("FAIL %s: expected %0d pulses, actual %0d", t_name[i],
                             t_exp[i], pulses);
                    test_errs++;
                end
            end
            K_CYC: begin
                // Second read strobe lands data cycles after the first
                read_reg(t_addr[i], first);
                repeat (int'(t_data[i]) - 2) @(posedge core_clk);
                read_reg(t_addr[i], got);
                assert ((got - first) === t_exp[i]) else begin
                    $display("FAIL %s: expected %0d, actual %0d", t_name[i], t_exp[i],
                             got - first);
                    test_errs++;
                end
            end
            default: begin
                $display("%s: unknown step kind in the table", t_name[i]);
                test_errs++;
            end
        endcase
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            $display("%-16s ok", name);
            tests_ok++;
        end else begin
            $display("%-16s %0d error(s)", name, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    initial begin
        hwif_out  = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        log_wr    = 1'b0;
        log_char  = '0;
        etrng_req = 1'b0;
        build_table();
        table_len = t_name.size();
        repeat (3) @(posedge core_clk);
        hwif_out <= 1'b1;
        for (int i = 0; i < table_len; i++) begin
            if (i > 0 && t_name[i] != t_name[i-1]) begin
                close_test(t_name[i-1]);
            end
            run_step(i);
        end
        close_test(t_name[table_len-1]);
        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        wait (table_len > 0);
        repeat (table_len * STEP_CYCLES + WATCH_MARGIN) @(posedge core_clk);
        $display("run timed out after %0d cycles before the table was done",
                 table_len * STEP_CYCLES + WATCH_MARGIN);
        $display("test failed");
        $finish;
    end

endmodule
